/* pkt_switch.f */
+incdir+src
src/pkt_pkg.sv
src/pkt_ingress.sv
src/pkt_buffer.sv
src/pkt_desc_fifo.sv
src/pkt_sched_ctrl.sv
src/pkt_egress.sv
src/pkt_switch_top.sv
test/pkt_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module pkt_switch_tb -f pkt_switch.f -o Vpkt_switch_tb

./obj_dir/Vpkt_switch_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* src/pkt_buffer.sv */
`timescale 1ns/1ns
`include "pkt_macros.svh"

module pkt_buffer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               wr_en,
    input  logic [`WORD_W-1:0] wr_data,
    input  logic               pop,
    output logic               full,
    output logic [`WORD_W-1:0] rd_data
);

    logic [`WORD_W-1:0] mem [`BUF_DEPTH];
    logic [`BUF_AW-1:0] wr_ptr;
    logic [`BUF_AW-1:0] rd_ptr;
    // one extra bit so a full ring can be told from an empty one
    logic [`BUF_AW:0]   count;
    logic               empty;

    assign full  = count == `BUF_AW'(`BUF_DEPTH - 1) + 1'b1;
    assign empty = count == '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + wr_en - pop;
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        if (pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);

endmodule

/* src/pkt_desc_fifo.sv */
`timescale 1ns/1ns
`include "pkt_macros.svh"

module pkt_desc_fifo import pkt_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      push,
    input  pkt_desc_t desc_in,
    input  logic      pop,
    output logic      full,
    output logic      empty,
    output pkt_desc_t desc_out
);

    pkt_desc_t           mem [`DESC_DEPTH];
    logic [`DESC_AW-1:0] wr_ptr;
    logic [`DESC_AW-1:0] rd_ptr;
    logic [`DESC_AW:0]   count;

    assign full     = count == `DESC_AW'(`DESC_DEPTH - 1) + 1'b1;
    assign empty    = count == '0;
    // head entry shown before it is popped
    assign desc_out = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + push;
            rd_ptr <= rd_ptr + pop;
            count  <= count + push - pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= desc_in;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);

endmodule

/* src/pkt_egress.sv */
`timescale 1ns/1ns

module pkt_egress import pkt_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      eg_valid,
    input  logic      eg_sop,
    input  logic      eg_eop,
    input  pkt_word_u eg_data,
    input  logic      out_ready,
    output logic      eg_ready,
    output logic      out_valid,
    output logic      out_sop,
    output logic      out_eop,
    output pkt_word_u out_data
);

    logic      skid_vld;
    logic      skid_sop;
    logic      skid_eop;
    pkt_word_u skid_data;
    logic      accept_in;
    // main slot is free or drains this cycle
    logic      take_main;
    logic      skid_nxt;

    assign accept_in = eg_valid && eg_ready;
    assign take_main = !out_valid || out_ready;
    assign skid_nxt  = take_main ? 1'b0 : (skid_vld || accept_in);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            skid_vld  <= 1'b0;
            eg_ready  <= 1'b0;
        end else begin
            if (take_main) begin
                out_valid <= skid_vld || accept_in;
            end
            skid_vld <= skid_nxt;
            // ready only from own state, high while a slot is free
            eg_ready <= !skid_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (take_main) begin
            out_sop  <= skid_vld ? skid_sop : eg_sop;
            out_eop  <= skid_vld ? skid_eop : eg_eop;
            out_data <= skid_vld ? skid_data : eg_data;
        end else if (accept_in) begin
            skid_sop  <= eg_sop;
            skid_eop  <= eg_eop;
            skid_data <= eg_data;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_sop)
            && $stable(out_eop));

endmodule

/* src/pkt_ingress.sv */
`timescale 1ns/1ns
`include "pkt_macros.svh"

module pkt_ingress import pkt_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  logic               in_sop,
    input  logic               in_eop,
    input  pkt_word_u          in_data,
    input  logic               hi_buf_full,
    input  logic               lo_buf_full,
    input  logic               hi_desc_full,
    input  logic               lo_desc_full,
    output logic               in_ready,
    output logic               hi_wr_en,
    output logic               lo_wr_en,
    output logic [`WORD_W-1:0] wr_data,
    output logic               hi_push,
    output logic               lo_push,
    output pkt_desc_t          desc
);

    // goes high one cycle after reset is released
    logic              run;
    logic              in_pkt;
    logic              cls_hi;
    logic [`LEN_W-1:0] cnt;
    pkt_hdr_t          hdr_q;

    logic              is_ctrl;
    logic              cur_hi;
    logic              buf_full;
    logic              desc_full;
    logic              accept;
    logic [`LEN_W-1:0] pkt_len;
    logic [`LEN_W-1:0] hdr_len;

    // the first word of a packet is the control word
    assign is_ctrl   = !in_pkt;
    assign cur_hi    = is_ctrl ? (in_data.hdr.prior >= `PRIO_HIGH_MIN) : cls_hi;
    assign buf_full  = cur_hi ? hi_buf_full : lo_buf_full;
    assign desc_full = cur_hi ? hi_desc_full : lo_desc_full;

    always_comb begin
        if (is_ctrl && in_eop) begin
            // zero-length packet, nothing goes to the buffer
            in_ready = run && !desc_full;
        end else if (in_eop) begin
            in_ready = run && !buf_full && !desc_full;
        end else begin
            in_ready = run && !buf_full;
        end
    end

    assign accept   = in_valid && in_ready;
    assign hi_wr_en = accept && !is_ctrl && cur_hi;
    assign lo_wr_en = accept && !is_ctrl && !cur_hi;
    assign wr_data  = in_data.raw;
    assign hi_push  = accept && in_eop && cur_hi;
    assign lo_push  = accept && in_eop && !cur_hi;

    // length as counted, not as announced
    assign pkt_len          = is_ctrl ? '0 : cnt + 1'b1;
    assign hdr_len          = is_ctrl ? in_data.hdr.length : hdr_q.length;
    assign desc.hdr.length  = pkt_len;
    assign desc.hdr.prior   = is_ctrl ? in_data.hdr.prior : hdr_q.prior;
    assign desc.hdr.dest    = is_ctrl ? in_data.hdr.dest : hdr_q.dest;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run    <= 1'b0;
            in_pkt <= 1'b0;
            cls_hi <= 1'b0;
            cnt    <= '0;
        end else begin
            run <= 1'b1;
            if (accept) begin
                if (in_eop) begin
                    in_pkt <= 1'b0;
                    cnt    <= '0;
                end else if (is_ctrl) begin
                    in_pkt <= 1'b1;
                    cls_hi <= cur_hi;
                    cnt    <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_ctrl) begin
            hdr_q <= in_data.hdr;
        end
    end

    a_sop_between: assert property (@(posedge clk) disable iff (!arst_n)
        accept && in_sop |-> !in_pkt);
    a_len_match: assert property (@(posedge clk) disable iff (!arst_n)
        accept && in_eop |-> pkt_len == hdr_len);
    a_len_max: assert property (@(posedge clk) disable iff (!arst_n)
        accept && is_ctrl |-> in_data.hdr.length <= `LEN_W'(`PKT_MAX_LEN));

endmodule

/* src/pkt_macros.svh */
`ifndef PKT_MACROS_SVH
`define PKT_MACROS_SVH

// word and control word field widths
`define WORD_W 16
`define LEN_W 9

// longest payload that a packet may carry, in words
`define PKT_MAX_LEN 32

// payload word buffer, one per class
`define BUF_DEPTH 64
`define BUF_AW 6

// descriptor queue, one per class
`define DESC_DEPTH 8
`define DESC_AW 3

// priorities from this value up go to the high class
`define PRIO_HIGH_MIN 3'd4

`endif

/* src/pkt_pkg.sv */
`include "pkt_macros.svh"

package pkt_pkg;

    // control word layout, dest sits in the low bits
    typedef struct packed {
        logic [`LEN_W-1:0] length;
        logic [2:0]        prior;
        logic [3:0]        dest;
    } pkt_hdr_t;

    // a bus word, read as payload or as a control word
    typedef union packed {
        logic [`WORD_W-1:0] raw;
        pkt_hdr_t           hdr;
    } pkt_word_u;

    // one buffered packet, length is the stored payload count
    typedef struct packed {
        pkt_hdr_t hdr;
    } pkt_desc_t;

endpackage

/* src/pkt_sched_ctrl.sv */
`timescale 1ns/1ns
`include "pkt_macros.svh"

module pkt_sched_ctrl import pkt_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               hi_empty,
    input  logic               lo_empty,
    input  pkt_desc_t          hi_desc,
    input  pkt_desc_t          lo_desc,
    input  logic [`WORD_W-1:0] hi_data,
    input  logic [`WORD_W-1:0] lo_data,
    input  logic               eg_ready,
    output logic               hi_desc_pop,
    output logic               lo_desc_pop,
    output logic               hi_buf_pop,
    output logic               lo_buf_pop,
    output logic               eg_valid,
    output logic               eg_sop,
    output logic               eg_eop,
    output pkt_word_u          eg_data
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_HDR  = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;

    logic [1:0]        state;
    // class being served, held until the packet ends
    logic              sel_hi;
    // payload words not yet popped from the buffer
    logic [`LEN_W-1:0] rem;
    // a read word waits on eg
    logic              data_vld;
    pkt_hdr_t          cur_hdr;
    logic              buf_pop;
    logic              eg_fire;

    // high class wins whenever it has a packet waiting
    assign hi_desc_pop = (state == S_IDLE) && !hi_empty;
    assign lo_desc_pop = (state == S_IDLE) && hi_empty && !lo_empty;

    // pop only with room downstream, so at most two words in flight
    assign buf_pop    = (state == S_DATA) && (rem != '0) && eg_ready;
    assign hi_buf_pop = buf_pop && sel_hi;
    assign lo_buf_pop = buf_pop && !sel_hi;

    assign eg_valid = (state == S_HDR) || ((state == S_DATA) && data_vld);
    assign eg_sop   = state == S_HDR;
    assign eg_eop   = (state == S_HDR) ? (cur_hdr.length == '0) : (rem == '0);
    assign eg_fire  = eg_valid && eg_ready;

    always_comb begin
        eg_data.raw = sel_hi ? hi_data : lo_data;
        if (state == S_HDR) begin
            // control word rebuilt from the descriptor
            eg_data.hdr = cur_hdr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            sel_hi   <= 1'b0;
            rem      <= '0;
            data_vld <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!hi_empty || !lo_empty) begin
                        sel_hi <= !hi_empty;
                        state  <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (eg_fire) begin
                        rem   <= cur_hdr.length;
                        state <= (cur_hdr.length == '0) ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    rem      <= rem - buf_pop;
                    data_vld <= buf_pop || (data_vld && !eg_fire);
                    if (eg_fire && eg_eop) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hi_desc_pop || lo_desc_pop) begin
            cur_hdr <= hi_desc_pop ? hi_desc.hdr : lo_desc.hdr;
        end
    end

    // a popped descriptor belongs to the class it is served as
    a_pop_class_hi: assert property (@(posedge clk) disable iff (!arst_n)
        hi_desc_pop |-> hi_desc.hdr.prior >= `PRIO_HIGH_MIN);
    a_pop_class_lo: assert property (@(posedge clk) disable iff (!arst_n)
        lo_desc_pop |-> lo_desc.hdr.prior < `PRIO_HIGH_MIN);
    a_eg_hold: assert property (@(posedge clk) disable iff (!arst_n)
        eg_valid && !eg_ready |=> eg_valid && $stable(eg_data) && $stable(eg_eop));

endmodule

/* src/pkt_switch_top.sv */
`timescale 1ns/1ns
`include "pkt_macros.svh"

module pkt_switch_top import pkt_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_valid,
    input  logic      in_sop,
    input  logic      in_eop,
    input  pkt_word_u in_data,
    input  logic      out_ready,
    output logic      in_ready,
    output logic      out_valid,
    output logic      out_sop,
    output logic      out_eop,
    output pkt_word_u out_data
);

    logic               hi_wr_en, lo_wr_en, hi_push, lo_push;
    logic               hi_buf_full, lo_buf_full, hi_desc_full, lo_desc_full;
    logic               hi_empty, lo_empty, hi_desc_pop, lo_desc_pop;
    logic               hi_buf_pop, lo_buf_pop;
    logic [`WORD_W-1:0] wr_data, hi_data, lo_data;
    pkt_desc_t          desc, hi_desc, lo_desc;
    logic               eg_valid, eg_ready, eg_sop, eg_eop;
    pkt_word_u          eg_data;

    pkt_ingress pkt_ingress_i (.clk, .arst_n, .in_valid, .in_sop, .in_eop, .in_data,
        .hi_buf_full, .lo_buf_full, .hi_desc_full, .lo_desc_full, .in_ready,
        .hi_wr_en, .lo_wr_en, .wr_data, .hi_push, .lo_push, .desc);

    // per-class payload storage
    pkt_buffer hi_buf_i (.clk, .arst_n, .wr_en(hi_wr_en), .wr_data, .pop(hi_buf_pop),
        .full(hi_buf_full), .rd_data(hi_data));
    pkt_buffer lo_buf_i (.clk, .arst_n, .wr_en(lo_wr_en), .wr_data, .pop(lo_buf_pop),
        .full(lo_buf_full), .rd_data(lo_data));

    // per-class descriptor queues
    pkt_desc_fifo hi_desc_i (.clk, .arst_n, .push(hi_push), .desc_in(desc),
        .pop(hi_desc_pop), .full(hi_desc_full), .empty(hi_empty), .desc_out(hi_desc));
    pkt_desc_fifo lo_desc_i (.clk, .arst_n, .push(lo_push), .desc_in(desc),
        .pop(lo_desc_pop), .full(lo_desc_full), .empty(lo_empty), .desc_out(lo_desc));

    pkt_sched_ctrl pkt_sched_ctrl_i (.clk, .arst_n, .hi_empty, .lo_empty, .hi_desc,
        .lo_desc, .hi_data, .lo_data, .eg_ready, .hi_desc_pop, .lo_desc_pop,
        .hi_buf_pop, .lo_buf_pop, .eg_valid, .eg_sop, .eg_eop, .eg_data);

    pkt_egress pkt_egress_i (.clk, .arst_n, .eg_valid, .eg_sop, .eg_eop, .eg_data,
        .out_ready, .eg_ready, .out_valid, .out_sop, .out_eop, .out_data);

endmodule

/* test/pkt_switch_tb.sv */
`timescale 1ns/1ns
`include "pkt_macros.svh"

module pkt_switch_tb import pkt_pkg::*; ();

    // packet index where each test phase starts in the vector file
    localparam int PRIO_FIRST = 8;
    localparam int FILL_FIRST = 13;
    localparam int NUM_PKTS   = 16;
    // stalled input cycles before out_ready is let go in the fill phase
    localparam int FILL_STALL = 8;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      in_valid;
    logic      in_sop;
    logic      in_eop;
    pkt_word_u in_data;
    logic      out_ready;
    logic      in_ready;
    logic      out_valid;
    logic      out_sop;
    logic      out_eop;
    pkt_word_u out_data;

    logic [`WORD_W-1:0] vec_words [$];
    int                 pkt_start [$];
    int                 total_words;
    bit                 loaded;

    // expected packets per class, in arrival order
    pkt_hdr_t           hi_hdr_q [$];
    pkt_hdr_t           lo_hdr_q [$];
    logic [`WORD_W-1:0] hi_word_q [$];
    logic [`WORD_W-1:0] lo_word_q [$];

    integer seed = 63;
    // out_ready draws from a stream of its own
    integer ready_seed = 63;

    bit hold;
    bit filling;
    bit saw_fill_stall;
    bit prio_watch;
    int stall_cnt;
    int lo_before_hi;
    int pkts_in;

    bit        mon_in_pkt;
    bit        mon_hi;
    int        mon_rem;
    bit        held;
    pkt_word_u held_data;
    logic      held_sop;
    logic      held_eop;

    pkt_switch_top pkt_switch_top_i (.clk, .arst_n, .in_valid, .in_sop, .in_eop, .in_data,
        .out_ready, .in_ready, .out_valid, .out_sop, .out_eop, .out_data);

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %0t %s expected %0b actual %0b",
                $time, name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input pkt_word_u exp, input pkt_word_u act);
        if (act.raw !== exp.raw) begin
            stop_with_failure($sformatf("ERROR %0t %s expected %04h actual %04h",
                $time, name, exp.raw, act.raw));
        end
    endtask

    task automatic check_hdr(input string name, input pkt_hdr_t exp, input pkt_hdr_t act);
        if (act.dest !== exp.dest) begin
            stop_with_failure($sformatf("ERROR %0t %s.dest expected %0h actual %0h",
                $time, name, exp.dest, act.dest));
        end
        if (act.prior !== exp.prior) begin
            stop_with_failure($sformatf("ERROR %0t %s.prior expected %0d actual %0d",
                $time, name, exp.prior, act.prior));
        end
        if (act.length !== exp.length) begin
            stop_with_failure($sformatf("ERROR %0t %s.length expected %0d actual %0d",
                $time, name, exp.length, act.length));
        end
    endtask

    function automatic bit is_high_class(input pkt_hdr_t h);
        return h.prior >= `PRIO_HIGH_MIN;
    endfunction

    task automatic load_vectors();
        int                 fd;
        int                 code;
        int                 i;
        string              line;
        logic [`WORD_W-1:0] w;
        pkt_word_u          ctrl;
        fd = $fopen("test/pkt_switch_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open test/pkt_switch_vectors.txt");
        end
        // two comment lines at the top
        code = $fgets(line, fd);
        code = $fgets(line, fd);
        code = $fscanf(fd, "%h", w);
        while (code == 1) begin
            ctrl.raw = w;
            pkt_start.push_back(vec_words.size());
            vec_words.push_back(w);
            for (i = 0; i < ctrl.hdr.length; i++) begin
                code = $fscanf(fd, "%h", w);
                if (code != 1) begin
                    stop_with_failure("vector file ends in the middle of a packet");
                end
                vec_words.push_back(w);
            end
            code = $fscanf(fd, "%h", w);
        end
        $fclose(fd);
        if (pkt_start.size() != NUM_PKTS) begin
            stop_with_failure($sformatf("vector file holds %0d packets instead of %0d",
                pkt_start.size(), NUM_PKTS));
        end
        total_words = vec_words.size();
        loaded = 1'b1;
    endtask

    // offer one word and wait until ingress takes it
    task automatic send_word(input logic sop, input logic eop, input logic [`WORD_W-1:0] w);
        in_valid    <= 1'b1;
        in_sop      <= sop;
        in_eop      <= eop;
        in_data.raw <= w;
        do begin
            @(posedge clk);
            if (filling && !in_ready) begin
                stall_cnt++;
                if (stall_cnt >= FILL_STALL) begin
                    saw_fill_stall = 1'b1;
                    hold <= 1'b0;
                end
            end
        end while (!in_ready);
    endtask

    task automatic send_packet(input int p);
        pkt_word_u ctrl;
        int        base;
        int        n;
        int        i;
        base = pkt_start[p];
        ctrl.raw = vec_words[base];
        n = ctrl.hdr.length;
        if (is_high_class(ctrl.hdr)) begin
            hi_hdr_q.push_back(ctrl.hdr);
            for (i = 1; i <= n; i++) begin
                hi_word_q.push_back(vec_words[base + i]);
            end
        end else begin
            lo_hdr_q.push_back(ctrl.hdr);
            for (i = 1; i <= n; i++) begin
                lo_word_q.push_back(vec_words[base + i]);
            end
        end
        for (i = 0; i <= n; i++) begin
            // random gaps only in the first phase
            if (p < PRIO_FIRST) begin
                while (($random(seed) & 3) == 0) begin
                    in_valid <= 1'b0;
                    @(posedge clk);
                end
            end
            send_word(i == 0, i == n, vec_words[base + i]);
        end
        pkts_in++;
    endtask

    function automatic bit model_empty();
        return hi_hdr_q.size() == 0 && lo_hdr_q.size() == 0
            && hi_word_q.size() == 0 && lo_word_q.size() == 0;
    endfunction

    // model state settles between edges, driving resumes on the next rising edge
    task automatic wait_for_drain();
        in_valid <= 1'b0;
        while (!model_empty()) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // match one accepted output word against the class queues
    task automatic take_output();
        pkt_hdr_t  exp_hdr;
        pkt_word_u exp_word;
        if (!mon_in_pkt) begin
            check_flag("out_sop", 1'b1, out_sop);
            mon_hi = is_high_class(out_data.hdr);
            if (mon_hi ? hi_hdr_q.size() == 0 : lo_hdr_q.size() == 0) begin
                stop_with_failure($sformatf("packet of priority %0d came out, none was sent",
                    out_data.hdr.prior));
            end
            if (mon_hi) begin
                exp_hdr = hi_hdr_q.pop_front();
            end else begin
                exp_hdr = lo_hdr_q.pop_front();
            end
            check_hdr("out_data.hdr", exp_hdr, out_data.hdr);
            mon_rem = exp_hdr.length;
            check_flag("out_eop", mon_rem == 0, out_eop);
            mon_in_pkt = mon_rem != 0;
            if (prio_watch && !mon_hi) begin
                lo_before_hi++;
            end else if (prio_watch) begin
                // only the low packet already under way may go first
                if (lo_before_hi > 1) begin
                    stop_with_failure($sformatf("high packet came out after %0d low packets",
                        lo_before_hi));
                end
                prio_watch = 1'b0;
            end
        end else begin
            check_flag("out_sop", 1'b0, out_sop);
            if (mon_hi) begin
                exp_word.raw = hi_word_q.pop_front();
            end else begin
                exp_word.raw = lo_word_q.pop_front();
            end
            check_word("out_data", exp_word, out_data);
            mon_rem--;
            check_flag("out_eop", mon_rem == 0, out_eop);
            mon_in_pkt = mon_rem != 0;
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n || hold) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($random(ready_seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            check_flag("out_valid", 1'b0, out_valid);
            check_flag("in_ready", 1'b0, in_ready);
        end else begin
            if (held) begin
                check_flag("out_valid held", 1'b1, out_valid);
                check_word("out_data held", held_data, out_data);
                check_flag("out_sop held", held_sop, out_sop);
                check_flag("out_eop held", held_eop, out_eop);
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
            held_sop  = out_sop;
            held_eop  = out_eop;
            if (out_valid && pkts_in == 0) begin
                stop_with_failure("output appeared before any packet was sent");
            end
            if (out_valid && out_ready) begin
                take_output();
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (40 * total_words + 200) @(posedge clk);
        stop_with_failure("timeout, the output stalled before all packets came out");
    end

    initial begin
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_sop      = 1'b0;
        in_eop      = 1'b0;
        in_data.raw = '0;
        out_ready   = 1'b0;
        load_vectors();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int p = 0; p < NUM_PKTS; p++) begin
            if (p == PRIO_FIRST) begin
                wait_for_drain();
                lo_before_hi = 0;
                prio_watch = 1'b1;
                hold <= 1'b1;
            end
            if (p == FILL_FIRST) begin
                wait_for_drain();
                stall_cnt = 0;
                filling = 1'b1;
                hold <= 1'b1;
            end
            send_packet(p);
            // whole priority burst is in, let the output run
            if (p == FILL_FIRST - 1) begin
                hold <= 1'b0;
            end
        end
        in_valid <= 1'b0;
        filling = 1'b0;
        hold <= 1'b0;
        if (!saw_fill_stall) begin
            stop_with_failure("in_ready never dropped while the low buffer was filling");
        end
        for (int i = 0; i < 500 && !model_empty(); i++) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (!model_empty()) begin
            stop_with_failure($sformatf("%0d high and %0d low packets never came out",
                hi_hdr_q.size(), lo_hdr_q.size()));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* test/pkt_switch_vectors.txt */
# one packet per line: control word in hex, then its payload words in hex
# control word bits: length 15:7, priority 6:4, destination 3:0
0212 a001 a002 a003 a004
01d7 b101 b102 b103
0021
0373 c301 c302 c303 c304 c305 c306
00c9 d401
0284 e501 e502 e503 e504 e505
006f
043a f701 f702 f703 f704 f705 f706 f707 f708
0191 1801 1802 1803
0222 1901 1902 1903 1904
0103 2a01 2a02
02b4 2b01 2b02 2b03 2b04 2b05
01e8 3c01 3c02 3c03
1015 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
1026 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
1037 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
